//--- design/neoBusPkg.sv
`default_nettype none

package neoBusPkg;

	// 68K word address, A0 is implied by the byte strobes
	typedef logic [23:1] addrT;
	// Bus and palette data word
	typedef logic [15:0] wordT;
	// Palette entry within one bank
	typedef logic [11:0] colorIdxT;
	// One video DAC channel
	typedef logic [6:0] chanT;

	// Decoded bus target
	typedef enum logic [1:0] {
		tgtNone,
		tgtWram,
		tgtLatch,
		tgtPal
	} targetT;

	// Decoder handshake states
	typedef enum logic [1:0] {
		stIdle,
		stWait,
		stAck,
		stErr
	} busStateT;

	// Work RAM size in words, as address bits
	localparam int wramAddrBits = 12;

	// Wait states per target, then the bus error timeout
	localparam int wramWait = 1;
	localparam int latchWait = 1;
	localparam int palWait = 2;
	localparam int busTimeout = 16;

	// Memory map, byte addresses
	localparam logic [23:0] wramBase = 24'h100000;
	// Byte offset bits inside the work RAM window
	localparam logic [23:0] wramMask = (24'd1 << (wramAddrBits + 1)) - 24'd1;
	localparam logic [23:0] latchBase = 24'h3A0000;
	localparam logic [23:0] latchSpan = 24'd32;
	localparam logic [23:0] palBase = 24'h400000;
	localparam logic [23:0] palSpan = 24'h002000;

	// Colour word and latch bit positions
	localparam int darkBit = 15;
	localparam int latchShadowIdx = 0;
	localparam int latchPalBankIdx = 7;

endpackage

`default_nettype wire

//--- design/addrDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module addrDecoder (
	input wire clk24M,
	input wire rst,
	input wire neoBusPkg::addrT addr,
	input wire nAs,
	input wire rw,
	output logic wramSel,
	output logic latchSel,
	output logic palSel,
	output logic cpuStrobe,
	output neoBusPkg::targetT rdTarget,
	output logic nDtack,
	output logic nBerr
);

	neoBusPkg::targetT target;
	neoBusPkg::busStateT state;
	logic [23:0] byteAddr;
	// Remaining wait cycles, wide enough for the timeout
	logic [4:0] waitCnt;
	logic [4:0] waitLoad;

	// Byte address for comparing against the map
	assign byteAddr = {addr, 1'b0};

	// Target decode from the address alone
	always_comb begin
		target = neoBusPkg::tgtNone;
		if ((byteAddr & ~neoBusPkg::wramMask) == neoBusPkg::wramBase) begin
			target = neoBusPkg::tgtWram;
		end else if (byteAddr >= neoBusPkg::latchBase &&
				byteAddr < neoBusPkg::latchBase + neoBusPkg::latchSpan) begin
			target = neoBusPkg::tgtLatch;
		end else if (byteAddr >= neoBusPkg::palBase &&
				byteAddr < neoBusPkg::palBase + neoBusPkg::palSpan) begin
			target = neoBusPkg::tgtPal;
		end
	end

	// Wait count per target
	// Unmapped runs the full timeout instead
	always_comb begin
		case (target)
			neoBusPkg::tgtWram: waitLoad = 5'(neoBusPkg::wramWait);
			neoBusPkg::tgtLatch: waitLoad = 5'(neoBusPkg::latchWait);
			neoBusPkg::tgtPal: waitLoad = 5'(neoBusPkg::palWait);
			default: waitLoad = 5'(neoBusPkg::busTimeout - 1);
		endcase
	end

	// Selects follow nAs for the whole access
	assign wramSel = !nAs && target == neoBusPkg::tgtWram;
	assign latchSel = !nAs && target == neoBusPkg::tgtLatch;
	assign palSel = !nAs && target == neoBusPkg::tgtPal;

	// Only the first cycle of an access, idle means a fresh cycle
	assign cpuStrobe = !nAs && state == neoBusPkg::stIdle;

	// Active low handshake straight from the state
	assign nDtack = state != neoBusPkg::stAck;
	assign nBerr = state != neoBusPkg::stErr;

	always_ff @(posedge clk24M) begin
		if (rst) begin
			state <= neoBusPkg::stIdle;
			waitCnt <= '0;
			rdTarget <= neoBusPkg::tgtNone;
		end else begin
			case (state)
				neoBusPkg::stIdle: begin
					if (!nAs) begin
						state <= neoBusPkg::stWait;
						waitCnt <= waitLoad;
						// Writes put zero on the read bus
						rdTarget <= rw ? target : neoBusPkg::tgtNone;
					end
				end
				neoBusPkg::stWait: begin
					if (nAs) begin
						// Master gave up early
						state <= neoBusPkg::stIdle;
					end else if (waitCnt == 5'd0) begin
						state <= (target == neoBusPkg::tgtNone) ? neoBusPkg::stErr
							: neoBusPkg::stAck;
					end else begin
						waitCnt <= waitCnt - 5'd1;
					end
				end
				// Hold until the master ends the cycle
				neoBusPkg::stAck, neoBusPkg::stErr: begin
					if (nAs) begin
						state <= neoBusPkg::stIdle;
					end
				end
				default: state <= neoBusPkg::stIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/workRam.sv
`timescale 1ns/100ps
`default_nettype none

module workRam (
	input wire clk24M,
	input wire wramSel,
	input wire cpuStrobe,
	input wire rw,
	input wire nUds,
	input wire nLds,
	input wire neoBusPkg::addrT addr,
	input wire neoBusPkg::wordT dataIn,
	output neoBusPkg::wordT rdData
);

	localparam int depth = 2 ** neoBusPkg::wramAddrBits;

	neoBusPkg::wordT mem [depth];
	logic [neoBusPkg::wramAddrBits-1:0] wordIdx;
	logic access;

	// Window offset, upper address bits only mirror
	assign wordIdx = addr[neoBusPkg::wramAddrBits:1];

	// One access per bus cycle
	assign access = wramSel && cpuStrobe;

	always_ff @(posedge clk24M) begin
		if (access && !rw) begin
			// Upper lane, even byte
			if (!nUds) begin
				mem[wordIdx][15:8] <= dataIn[15:8];
			end
			// Lower lane, odd byte
			if (!nLds) begin
				mem[wordIdx][7:0] <= dataIn[7:0];
			end
		end
	end

	// Registered read
	// Holds until the next read strobe
	always_ff @(posedge clk24M) begin
		if (access && rw) begin
			rdData <= mem[wordIdx];
		end
	end

endmodule

`default_nettype wire

//--- design/sysLatch.sv
`timescale 1ns/100ps
`default_nettype none

module sysLatch (
	input wire clk24M,
	input wire rst,
	input wire latchSel,
	input wire cpuStrobe,
	input wire rw,
	input wire neoBusPkg::addrT addr,
	output logic [7:0] sysFlags,
	output logic shadow,
	output logic palBank
);

	logic wrEn;
	logic [2:0] bitSel;
	logic bitVal;

	// Writes only, reads fall through as zero
	assign wrEn = latchSel && cpuStrobe && !rw;

	// Bit number on A3..A1
	assign bitSel = addr[3:1];

	// New value carried on A4
	// Data bus never reaches the latch
	assign bitVal = addr[4];

	// Addressable latch, one bit per write
	always_ff @(posedge clk24M) begin
		if (rst) begin
			sysFlags <= '0;
		end else if (wrEn) begin
			sysFlags[bitSel] <= bitVal;
		end
	end

	// Dims the whole picture
	assign shadow = sysFlags[neoBusPkg::latchShadowIdx];

	// Palette bank for CPU and video alike
	assign palBank = sysFlags[neoBusPkg::latchPalBankIdx];

endmodule

`default_nettype wire

//--- design/paletteRam.sv
`timescale 1ns/100ps
`default_nettype none

module paletteRam (
	input wire clk24M,
	input wire palSel,
	input wire cpuStrobe,
	input wire rw,
	input wire nUds,
	input wire nLds,
	input wire palBank,
	input wire neoBusPkg::addrT addr,
	input wire neoBusPkg::wordT dataIn,
	input wire neoBusPkg::colorIdxT pixIndex,
	input wire pixValid,
	output neoBusPkg::wordT rdData,
	output neoBusPkg::wordT pixWord,
	output logic pixWordValid
);

	// Two banks of 4096 words
	localparam int idxBits = $bits(neoBusPkg::colorIdxT);
	localparam int depth = 2 ** (idxBits + 1);

	neoBusPkg::wordT mem [depth];
	logic [idxBits:0] cpuIdx;
	logic [idxBits:0] pixIdx;
	logic access;

	// Bank bit on top for both ports
	assign cpuIdx = {palBank, addr[idxBits:1]};
	assign pixIdx = {palBank, pixIndex};

	assign access = palSel && cpuStrobe;

	// CPU writes, byte laned
	always_ff @(posedge clk24M) begin
		if (access && !rw) begin
			if (!nUds) begin
				mem[cpuIdx][15:8] <= dataIn[15:8];
			end
			if (!nLds) begin
				mem[cpuIdx][7:0] <= dataIn[7:0];
			end
		end
	end

	// CPU read, registered on the strobe
	always_ff @(posedge clk24M) begin
		if (access && rw) begin
			rdData <= mem[cpuIdx];
		end
	end

	// Video read port
	// One pixel per clock, no stall
	always_ff @(posedge clk24M) begin
		if (pixValid) begin
			pixWord <= mem[pixIdx];
		end
	end

	// Valid travels with the word
	always_ff @(posedge clk24M) begin
		pixWordValid <= pixValid;
	end

endmodule

`default_nettype wire

//--- design/videoOut.sv
`timescale 1ns/100ps
`default_nettype none

module videoOut (
	input wire clk24M,
	input wire rst,
	input wire neoBusPkg::wordT pixWord,
	input wire pixWordValid,
	input wire shadow,
	input wire blank,
	output neoBusPkg::chanT red,
	output neoBusPkg::chanT green,
	output neoBusPkg::chanT blue,
	output logic rgbValid
);

	// Component to DAC level
	function automatic neoBusPkg::chanT toLevel(
		input logic [4:0] comp,
		input logic dark,
		input logic shade,
		input logic off
	);
		neoBusPkg::chanT level;
		// comp * 4, plus 2 unless dark
		level = {comp, ~dark, 1'b0};
		if (shade) begin
			level = level >> 1;
		end
		if (off) begin
			level = '0;
		end
		return level;
	endfunction

	logic dark;
	logic [4:0] redComp;
	logic [4:0] greenComp;
	logic [4:0] blueComp;

	assign dark = pixWord[neoBusPkg::darkBit];

	// Nibble is the high part, bits 14..12 give the LSBs
	assign redComp = {pixWord[11:8], pixWord[14]};
	assign greenComp = {pixWord[7:4], pixWord[13]};
	assign blueComp = {pixWord[3:0], pixWord[12]};

	// Output stage, shadow and blank arrive already aligned with pixWord
	always_ff @(posedge clk24M) begin
		red <= toLevel(redComp, dark, shadow, blank);
		green <= toLevel(greenComp, dark, shadow, blank);
		blue <= toLevel(blueComp, dark, shadow, blank);
	end

	always_ff @(posedge clk24M) begin
		if (rst) begin
			rgbValid <= 1'b0;
		end else begin
			rgbValid <= pixWordValid;
		end
	end

endmodule

`default_nettype wire

//--- design/neoBusTop.sv
`timescale 1ns/100ps
`default_nettype none

module neoBusTop (
	input wire clk24M,
	input wire rst,
	input wire neoBusPkg::addrT addr,
	input wire neoBusPkg::wordT dataIn,
	input wire rw,
	input wire nAs,
	input wire nUds,
	input wire nLds,
	input wire neoBusPkg::colorIdxT pixIndex,
	input wire pixValid,
	input wire blank,
	output neoBusPkg::wordT dataOut,
	output logic nDtack,
	output logic nBerr,
	output logic [7:0] sysFlags,
	output neoBusPkg::chanT red,
	output neoBusPkg::chanT green,
	output neoBusPkg::chanT blue,
	output logic rgbValid
);

	logic wramSel;
	logic latchSel;
	logic palSel;
	logic cpuStrobe;
	neoBusPkg::targetT rdTarget;
	neoBusPkg::wordT wramRd;
	neoBusPkg::wordT palRd;
	neoBusPkg::wordT pixWord;
	logic pixWordValid;
	logic shadow;
	logic palBank;
	logic shadowDly;
	logic blankDly;

	addrDecoder decoder (
		.clk24M(clk24M), .rst(rst), .addr(addr), .nAs(nAs), .rw(rw),
		.wramSel(wramSel), .latchSel(latchSel), .palSel(palSel),
		.cpuStrobe(cpuStrobe), .rdTarget(rdTarget), .nDtack(nDtack), .nBerr(nBerr)
	);

	workRam wram (
		.clk24M(clk24M), .wramSel(wramSel), .cpuStrobe(cpuStrobe), .rw(rw),
		.nUds(nUds), .nLds(nLds), .addr(addr), .dataIn(dataIn), .rdData(wramRd)
	);

	sysLatch latch (
		.clk24M(clk24M), .rst(rst), .latchSel(latchSel), .cpuStrobe(cpuStrobe),
		.rw(rw), .addr(addr), .sysFlags(sysFlags), .shadow(shadow), .palBank(palBank)
	);

	paletteRam pal (
		.clk24M(clk24M), .palSel(palSel), .cpuStrobe(cpuStrobe), .rw(rw),
		.nUds(nUds), .nLds(nLds), .palBank(palBank), .addr(addr), .dataIn(dataIn),
		.pixIndex(pixIndex), .pixValid(pixValid), .rdData(palRd),
		.pixWord(pixWord), .pixWordValid(pixWordValid)
	);

	// Shadow and blank ride along with the palette read
	always_ff @(posedge clk24M) begin
		shadowDly <= shadow;
		blankDly <= blank;
	end

	videoOut vout (
		.clk24M(clk24M), .rst(rst), .pixWord(pixWord), .pixWordValid(pixWordValid),
		.shadow(shadowDly), .blank(blankDly),
		.red(red), .green(green), .blue(blue), .rgbValid(rgbValid)
	);

	// Read data by the target latched at the strobe
	// Latch and unmapped read as zero
	always_comb begin
		case (rdTarget)
			neoBusPkg::tgtWram: dataOut = wramRd;
			neoBusPkg::tgtPal: dataOut = palRd;
			default: dataOut = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- dv/neoBusTb.sv
`timescale 1ns/100ps
`default_nettype none

module neoBusTb;

	// Table operations
	typedef enum logic [2:0] {opWr, opRd, opErr, opFlags, opPix} opT;

	localparam int clkPeriod = 8;
	localparam int resetCycles = 5;
	localparam int maxEntries = 160;
	// Watchdog budget per table entry
	localparam int cyclesPerEntry = 40;
	// Gap between work RAM and latch
	localparam logic [23:0] holeAddr = 24'h200000;

	logic clk24M;
	logic rst;
	neoBusPkg::addrT addr;
	neoBusPkg::wordT dataIn;
	logic rw;
	logic nAs;
	logic nUds;
	logic nLds;
	neoBusPkg::colorIdxT pixIndex;
	logic pixValid;
	logic blank;
	neoBusPkg::wordT dataOut;
	logic nDtack;
	logic nBerr;
	logic [7:0] sysFlags;
	neoBusPkg::chanT red;
	neoBusPkg::chanT green;
	neoBusPkg::chanT blue;
	logic rgbValid;

	// Stimulus table, strobes as lane enables {upper, lower}
	opT opTab [maxEntries];
	logic [23:0] addrTab [maxEntries];
	logic [15:0] dataTab [maxEntries];
	logic [1:0] strbTab [maxEntries];
	logic [31:0] expTab [maxEntries];
	int latTab [maxEntries];
	int numEntries;
	logic tableReady;

	// Reference model
	neoBusPkg::wordT wramModel [4096];
	neoBusPkg::wordT palModel [8192];
	logic [7:0] flagsModel;
	integer seed;

	neoBusTop uut (
		.clk24M(clk24M), .rst(rst), .addr(addr), .dataIn(dataIn), .rw(rw), .nAs(nAs),
		.nUds(nUds), .nLds(nLds), .pixIndex(pixIndex), .pixValid(pixValid), .blank(blank),
		.dataOut(dataOut), .nDtack(nDtack), .nBerr(nBerr), .sysFlags(sysFlags),
		.red(red), .green(green), .blue(blue), .rgbValid(rgbValid)
	);

	initial begin
		clk24M = 1'b0;
		forever begin
			#(clkPeriod / 2);
			clk24M = ~clk24M;
		end
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			abortRun($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	// Byte lane rule, only enabled lanes change
	function automatic neoBusPkg::wordT mergeLanes(input neoBusPkg::wordT old,
			input neoBusPkg::wordT d, input logic [1:0] lanes);
		neoBusPkg::wordT r;
		r = old;
		if (lanes[1]) begin
			r[15:8] = d[15:8];
		end
		if (lanes[0]) begin
			r[7:0] = d[7:0];
		end
		return r;
	endfunction

	// Level = component * 4, +2 when not dark, halved by shadow, zero on blank
	function automatic neoBusPkg::chanT colourLevel(input logic [3:0] nib, input logic lsb,
			input logic dark, input logic shade, input logic blk);
		int level;
		level = (int'(nib) * 2 + int'(lsb)) * 4;
		if (!dark) begin
			level = level + 2;
		end
		if (shade) begin
			level = level / 2;
		end
		if (blk) begin
			level = 0;
		end
		return 7'(level);
	endfunction

	function automatic int palSlot(input int idx);
		return int'(flagsModel[neoBusPkg::latchPalBankIdx]) * 4096 + idx;
	endfunction

	task automatic addEntry(input opT op, input logic [23:0] a, input logic [15:0] d,
			input logic [1:0] lanes, input logic [31:0] e, input int lat);
		opTab[numEntries] = op;
		addrTab[numEntries] = a;
		dataTab[numEntries] = d;
		strbTab[numEntries] = lanes;
		expTab[numEntries] = e;
		latTab[numEntries] = lat;
		numEntries++;
	endtask

	task automatic wramWrite(input int word, input neoBusPkg::wordT d, input logic [1:0] lanes);
		wramModel[word] = mergeLanes(wramModel[word], d, lanes);
		addEntry(opWr, neoBusPkg::wramBase + 24'(word * 2), d, lanes, 32'h0, 2);
	endtask

	task automatic wramRead(input int word);
		addEntry(opRd, neoBusPkg::wramBase + 24'(word * 2), 16'h0, 2'b11,
			{16'h0, wramModel[word]}, 2);
	endtask

	// Bit number on A3..A1, new value on A4, data word is noise
	task automatic latchWrite(input int bitNum, input logic val);
		flagsModel[bitNum] = val;
		addEntry(opWr, neoBusPkg::latchBase + 24'({val, 3'(bitNum), 1'b0}),
			16'($random(seed)), 2'b11, 32'h0, 2);
		addEntry(opFlags, 24'h0, 16'h0, 2'b00, {24'h0, flagsModel}, 0);
	endtask

	task automatic palWrite(input int idx, input neoBusPkg::wordT d, input logic [1:0] lanes);
		palModel[palSlot(idx)] = mergeLanes(palModel[palSlot(idx)], d, lanes);
		addEntry(opWr, neoBusPkg::palBase + 24'(idx * 2), d, lanes, 32'h0, 3);
	endtask

	task automatic palRead(input int idx);
		addEntry(opRd, neoBusPkg::palBase + 24'(idx * 2), 16'h0, 2'b11,
			{16'h0, palModel[palSlot(idx)]}, 3);
	endtask

	// Expected {red, green, blue} from current bank and shadow
	task automatic pixelEntry(input int idx, input logic blk);
		neoBusPkg::wordT w;
		logic shade;
		w = palModel[palSlot(idx)];
		shade = flagsModel[neoBusPkg::latchShadowIdx];
		addEntry(opPix, 24'(idx), {15'h0, blk}, 2'b00,
			{11'h0, colourLevel(w[11:8], w[14], w[15], shade, blk),
			colourLevel(w[7:4], w[13], w[15], shade, blk),
			colourLevel(w[3:0], w[12], w[15], shade, blk)}, 2);
	endtask

	task automatic buildTable;
		int k;
		seed = 78671;
		numEntries = 0;
		flagsModel = '0;
		// Full words first so both lanes are known
		wramWrite(0, 16'h1234, 2'b11);
		wramWrite(1, 16'hABCD, 2'b11);
		wramWrite(4095, 16'h5AA5, 2'b11);
		wramRead(0);
		wramRead(1);
		wramRead(4095);
		wramWrite(1, 16'hEE77, 2'b10);
		wramRead(1);
		wramWrite(1, 16'h3311, 2'b01);
		wramRead(1);
		// Set bits one by one, clear a few
		for (k = 1; k < 7; k++) begin
			latchWrite(k, 1'b1);
		end
		latchWrite(3, 1'b0);
		latchWrite(5, 1'b0);
		// Latch reads back as zero
		addEntry(opRd, neoBusPkg::latchBase, 16'h0, 2'b11, 32'h0, 2);
		// Same indices in both banks
		for (k = 0; k < 10; k++) begin
			palWrite(k, 16'($random(seed)), 2'b11);
		end
		latchWrite(7, 1'b1);
		for (k = 0; k < 10; k++) begin
			palWrite(k, 16'($random(seed)), 2'b11);
		end
		palRead(2);
		latchWrite(7, 1'b0);
		palRead(2);
		palWrite(3, 16'($random(seed)), 2'b10);
		palRead(3);
		// Dark bit set and clear
		palWrite(8, 16'($random(seed)) | 16'h8000, 2'b11);
		palWrite(9, 16'($random(seed)) & 16'h7FFF, 2'b11);
		// Video bursts, bank 0 then bank 1, shadow off and on
		for (k = 0; k < 10; k++) begin
			pixelEntry(k, k == 4);
		end
		latchWrite(0, 1'b1);
		for (k = 9; k >= 0; k--) begin
			pixelEntry(k, k == 7);
		end
		latchWrite(7, 1'b1);
		for (k = 0; k < 10; k++) begin
			pixelEntry(k, 1'b0);
		end
		latchWrite(0, 1'b0);
		for (k = 0; k < 10; k++) begin
			pixelEntry(k, k == 9);
		end
		// Holes, each followed by a good access
		addEntry(opErr, holeAddr, 16'h0, 2'b11, 32'h0, neoBusPkg::busTimeout);
		wramRead(4095);
		addEntry(opErr, neoBusPkg::latchBase + neoBusPkg::latchSpan, 16'h0, 2'b11, 32'h0,
			neoBusPkg::busTimeout);
		palRead(5);
		addEntry(opErr, neoBusPkg::palBase + neoBusPkg::palSpan, 16'h0, 2'b11, 32'h0,
			neoBusPkg::busTimeout);
		wramRead(0);
	endtask

	// Phase is always 1 ns after a rising edge
	task automatic startAccess(input int i, input logic read);
		addr = addrTab[i][23:1];
		dataIn = dataTab[i];
		rw = read;
		nUds = !strbTab[i][1];
		nLds = !strbTab[i][0];
		nAs = 1'b0;
	endtask

	// First edge samples nAs, latency counts from there
	task automatic awaitResponse(input int i, input logic wantErr);
		int edges;
		logic done;
		edges = 0;
		done = 1'b0;
		while (!done) begin
			@(posedge clk24M);
			#1;
			edges++;
			check(wantErr ? "nDtack" : "nBerr", 32'(wantErr ? nDtack : nBerr), 32'h1);
			done = (wantErr ? nBerr : nDtack) === 1'b0;
			if (!done && edges > neoBusPkg::busTimeout + 8) begin
				abortRun("bus access got neither an acknowledge nor a bus error");
			end
		end
		check("ackLatency", 32'(edges - 1), 32'(latTab[i]));
	endtask

	// Response releases one edge after nAs rises
	task automatic endAccess;
		nAs = 1'b1;
		rw = 1'b1;
		nUds = 1'b1;
		nLds = 1'b1;
		@(posedge clk24M);
		#1;
		check("nDtack", 32'(nDtack), 32'h1);
		check("nBerr", 32'(nBerr), 32'h1);
	endtask

	task automatic busWrite(input int i);
		startAccess(i, 1'b0);
		awaitResponse(i, 1'b0);
		endAccess();
	endtask

	task automatic busRead(input int i);
		startAccess(i, 1'b1);
		awaitResponse(i, 1'b0);
		check("dataOut", 32'(dataOut), expTab[i]);
		endAccess();
	endtask

	task automatic busExpectErr(input int i);
		startAccess(i, 1'b1);
		awaitResponse(i, 1'b1);
		endAccess();
	endtask

	// Back to back stream, pixel k shows two edges after its drive
	task automatic pixel(input int first, input int last);
		int t;
		int k;
		check("rgbValid", 32'(rgbValid), 32'h0);
		for (t = first; t <= last + 3; t++) begin
			k = t - 2;
			if (k >= first && k <= last) begin
				check("rgbValid", 32'(rgbValid), 32'h1);
				check("red", 32'(red), 32'(expTab[k][20:14]));
				check("green", 32'(green), 32'(expTab[k][13:7]));
				check("blue", 32'(blue), 32'(expTab[k][6:0]));
			end else if (t == last + 3) begin
				check("rgbValid", 32'(rgbValid), 32'h0);
			end
			pixValid = t <= last;
			pixIndex = (t <= last) ? addrTab[t][11:0] : '0;
			blank = (t <= last) ? dataTab[t][0] : 1'b0;
			@(posedge clk24M);
			#1;
		end
	endtask

	// Watchdog sized from the table
	initial begin
		wait (tableReady === 1'b1);
		#((resetCycles + numEntries * cyclesPerEntry) * clkPeriod);
		abortRun("watchdog expired before the stimulus table finished");
	end

	initial begin
		int i;
		int last;
		tableReady = 1'b0;
		rst = 1'b1;
		addr = '0;
		dataIn = '0;
		rw = 1'b1;
		nAs = 1'b1;
		nUds = 1'b1;
		nLds = 1'b1;
		pixIndex = '0;
		pixValid = 1'b0;
		blank = 1'b0;
		buildTable();
		tableReady = 1'b1;
		repeat (resetCycles) @(posedge clk24M);
		#1;
		rst = 1'b0;
		// Idle state out of reset
		check("nDtack", 32'(nDtack), 32'h1);
		check("nBerr", 32'(nBerr), 32'h1);
		check("rgbValid", 32'(rgbValid), 32'h0);
		check("sysFlags", 32'(sysFlags), 32'h0);
		i = 0;
		while (i < numEntries) begin
			case (opTab[i])
				opWr: busWrite(i);
				opRd: busRead(i);
				opErr: busExpectErr(i);
				opFlags: check("sysFlags", 32'(sysFlags), expTab[i]);
				default: begin
					// Gather the run of pixels
					last = i;
					while (last + 1 < numEntries && opTab[last + 1] == opPix) begin
						last++;
					end
					pixel(i, last);
					i = last;
				end
			endcase
			i++;
		end
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
design/neoBusPkg.sv
design/addrDecoder.sv
design/workRam.sv
design/sysLatch.sv
design/paletteRam.sv
design/videoOut.sv
design/neoBusTop.sv
dv/neoBusTb.sv

//--- run.sh
#!/bin/sh
# Build and run the bus testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f list.f --top-module neoBusTb -Mdir obj_dir

./obj_dir/VneoBusTb > sim.log 2>&1 || true
cat sim.log

if grep -qx '>>> PASS' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
